// File: hw/vred_macros.svh
`ifndef VRED_MACROS_SVH
`define VRED_MACROS_SVH

// vector register length in bits
`define VRED_VLEN 128

// largest register group
`define VRED_NREGS 4

// whole operand group, VLEN * NREGS
`define VRED_WORK_W 512

// working register after the first tree level
`define VRED_HALF_W 256

// scalar operand and result
`define VRED_XLEN 32

// enough for up to 6 tree levels
`define VRED_LEVEL_W 3

`endif

// File: hw/vred_pkg.sv
`default_nettype none

`include "vred_macros.svh"

package vred_pkg;

    // reduction opcodes
    typedef enum logic [2:0] {
        VRED_VREDSUM = 3'd0,
        VRED_VREDMAX = 3'd1
    } vred_op_e;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } vred_sew_e;

    typedef enum logic [1:0] {
        LMUL_1 = 2'd0,
        LMUL_2 = 2'd1,
        LMUL_4 = 2'd2
    } vred_lmul_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } vred_state_e;

    typedef logic [`VRED_VLEN-1:0]    vreg_t;
    typedef logic [`VRED_WORK_W-1:0]  work_t;
    typedef logic [`VRED_HALF_W-1:0]  half_t;
    typedef logic [`VRED_XLEN-1:0]    scalar_t;
    typedef logic [`VRED_LEVEL_W-1:0] level_t;

endpackage

`default_nettype wire

// File: hw/vred_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vred_ctrl (
    input  wire                       clk,
    input  wire                       nrst,
    input  wire                       req,
    input  wire vred_pkg::vred_op_e   op_instr,
    input  wire vred_pkg::vred_sew_e  sew,
    input  wire vred_pkg::vred_lmul_e lmul,
    output logic                      ack,
    output logic                      load,
    output logic                      step,
    output logic                      last,
    output vred_pkg::vred_op_e        op_q,
    output vred_pkg::vred_sew_e       sew_q
);

    vred_pkg::vred_state_e state_q;
    vred_pkg::level_t      level_q;
    vred_pkg::level_t      n_q;
    vred_pkg::level_t      n_levels;

    // log2(VLEN * group / SEW), i.e. 4 + lmul - sew
    assign n_levels = vred_pkg::level_t'(4)
                    + vred_pkg::level_t'(lmul)
                    - vred_pkg::level_t'(sew);

    // sampling edge is level 1
    assign load = (state_q == vred_pkg::IDLE) && req;

    // levels 2 to N
    assign step = (state_q == vred_pkg::RUN);
    assign last = step && (level_q == n_q);

    // ack holds for as long as we sit in DONE
    assign ack = (state_q == vred_pkg::DONE);

    always_ff @(posedge clk)
    begin
        if (!nrst)
        begin
            state_q <= vred_pkg::IDLE;
            level_q <= '0;
            n_q     <= '0;
            op_q    <= vred_pkg::VRED_VREDSUM;
            sew_q   <= vred_pkg::SEW_8;
        end
        else
        begin
            case (state_q)
                vred_pkg::IDLE:
                begin
                    if (req)
                    begin
                        state_q <= vred_pkg::RUN;
                        level_q <= vred_pkg::level_t'(2);
                        n_q     <= n_levels;
                        op_q    <= op_instr;
                        sew_q   <= sew;
                    end
                end
                vred_pkg::RUN:
                begin
                    if (last)
                        state_q <= vred_pkg::DONE;
                    else
                        level_q <= level_q + vred_pkg::level_t'(1);
                end
                vred_pkg::DONE:
                begin
                    // four-phase return, wait for req to drop
                    if (!req)
                        state_q <= vred_pkg::IDLE;
                end
                default:
                begin
                    state_q <= vred_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/vred_pair_combine.sv
`timescale 1ns/1ps
`default_nettype none

`include "vred_macros.svh"

module vred_pair_combine (
    input  wire vred_pkg::work_t     data_in,
    input  wire vred_pkg::vred_op_e  op,
    input  wire vred_pkg::vred_sew_e sew,
    output vred_pkg::half_t          data_out
);

    localparam int NUM_SEW = 3;

    vred_pkg::half_t lane_out [NUM_SEW];
    logic            is_max;

    assign is_max = (op == vred_pkg::VRED_VREDMAX);

    // one candidate level per element width, picked below
    for (genvar w = 0; w < NUM_SEW; w++)
    begin : g_sew
        localparam int EW = 8 << w;
        localparam int NP = `VRED_HALF_W / EW;

        wire [`VRED_HALF_W-1:0] packed_out;

        for (genvar p = 0; p < NP; p++)
        begin : g_pair
            wire [EW-1:0] a;
            wire [EW-1:0] b;
            wire [EW-1:0] larger;

            assign a = data_in[2*p*EW +: EW];
            assign b = data_in[(2*p+1)*EW +: EW];

            // ties keep the lower element
            assign larger = ($signed(a) >= $signed(b)) ? a : b;

            // sum wraps at the element width
            assign packed_out[p*EW +: EW] = is_max ? larger : a + b;
        end

        assign lane_out[w] = packed_out;
    end

    always_comb
    begin
        data_out = lane_out[0];
        case (sew)
            vred_pkg::SEW_8:  data_out = lane_out[0];
            vred_pkg::SEW_16: data_out = lane_out[1];
            vred_pkg::SEW_32: data_out = lane_out[2];
        endcase
    end

endmodule

`default_nettype wire

// File: hw/vred_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "vred_macros.svh"

module vred_datapath (
    input  wire                       clk,
    input  wire                       nrst,
    input  wire                       load,
    input  wire                       step,
    input  wire                       last,
    input  wire vred_pkg::vred_op_e   op_q,
    input  wire vred_pkg::vred_sew_e  sew_q,
    input  wire vred_pkg::vred_op_e   op_instr,
    input  wire vred_pkg::vred_sew_e  sew,
    input  wire vred_pkg::vred_lmul_e lmul,
    input  wire vred_pkg::vreg_t      vec_regb_1,
    input  wire vred_pkg::vreg_t      vec_regb_2,
    input  wire vred_pkg::vreg_t      vec_regb_3,
    input  wire vred_pkg::vreg_t      vec_regb_4,
    input  wire vred_pkg::scalar_t    vec_rega,
    output vred_pkg::scalar_t         result
);

    vred_pkg::vreg_t        regs [`VRED_NREGS];
    vred_pkg::vreg_t        ident;
    logic [`VRED_NREGS-1:0] reg_active;
    vred_pkg::work_t        masked;
    vred_pkg::work_t        comb_in;
    vred_pkg::vred_op_e     comb_op;
    vred_pkg::vred_sew_e    comb_sew;
    vred_pkg::half_t        comb_out;
    vred_pkg::half_t        work_q;
    vred_pkg::scalar_t      scalar_q;
    vred_pkg::scalar_t      elem_sx;
    vred_pkg::scalar_t      scalar_sx;
    vred_pkg::scalar_t      elem_mask;
    vred_pkg::scalar_t      merged;

    assign regs[0] = vec_regb_1;
    assign regs[1] = vec_regb_2;
    assign regs[2] = vec_regb_3;
    assign regs[3] = vec_regb_4;

    // identity fill: zero for sum, most negative for max
    always_comb
    begin
        ident = '0;
        if (op_instr == vred_pkg::VRED_VREDMAX)
        begin
            case (sew)
                vred_pkg::SEW_8:  ident = {(`VRED_VLEN / 8){8'h80}};
                vred_pkg::SEW_16: ident = {(`VRED_VLEN / 16){16'h8000}};
                vred_pkg::SEW_32: ident = {(`VRED_VLEN / 32){32'h8000_0000}};
            endcase
        end
    end

    // registers past the group get the identity
    always_comb
    begin
        for (int r = 0; r < `VRED_NREGS; r++)
        begin
            reg_active[r] = (r < (1 << int'(lmul)));
            masked[r*`VRED_VLEN +: `VRED_VLEN] = reg_active[r] ? regs[r] : ident;
        end
    end

    // first level from the operands, later ones from work_q
    always_comb
    begin
        if (load)
        begin
            comb_in  = masked;
            comb_op  = op_instr;
            comb_sew = sew;
        end
        else
        begin
            comb_in  = vred_pkg::work_t'(work_q);
            comb_op  = op_q;
            comb_sew = sew_q;
        end
    end

    vred_pair_combine u_combine (
        .data_in  (comb_in),
        .op       (comb_op),
        .sew      (comb_sew),
        .data_out (comb_out)
    );

    always_ff @(posedge clk)
    begin
        if (load || step)
            work_q <= comb_out;
        if (load)
            scalar_q <= vec_rega;
    end

    // sign-extend element 0 and scalar, fold, then trim to SEW
    always_comb
    begin
        elem_sx   = comb_out[`VRED_XLEN-1:0];
        scalar_sx = scalar_q;
        elem_mask = '1;
        case (sew_q)
            vred_pkg::SEW_8:
            begin
                elem_sx   = {{(`VRED_XLEN-8){comb_out[7]}}, comb_out[7:0]};
                scalar_sx = {{(`VRED_XLEN-8){scalar_q[7]}}, scalar_q[7:0]};
                elem_mask = vred_pkg::scalar_t'(8'hff);
            end
            vred_pkg::SEW_16:
            begin
                elem_sx   = {{(`VRED_XLEN-16){comb_out[15]}}, comb_out[15:0]};
                scalar_sx = {{(`VRED_XLEN-16){scalar_q[15]}}, scalar_q[15:0]};
                elem_mask = vred_pkg::scalar_t'(16'hffff);
            end
            vred_pkg::SEW_32:
            begin
                elem_mask = '1;
            end
        endcase

        if (op_q == vred_pkg::VRED_VREDMAX)
            merged = ($signed(elem_sx) >= $signed(scalar_sx)) ? elem_sx : scalar_sx;
        else
            merged = elem_sx + scalar_sx;
    end

    always_ff @(posedge clk)
    begin
        if (!nrst)
            result <= '0;
        else if (last)
            result <= merged & elem_mask;
    end

endmodule

`default_nettype wire

// File: hw/vred_top.sv
`timescale 1ns/1ps
`default_nettype none

module vred_top (
    input  wire                       clk,
    input  wire                       nrst,
    input  wire                       req,
    input  wire vred_pkg::vred_op_e   op_instr,
    input  wire vred_pkg::vred_sew_e  sew,
    input  wire vred_pkg::vred_lmul_e lmul,
    input  wire vred_pkg::vreg_t      vec_regb_1,
    input  wire vred_pkg::vreg_t      vec_regb_2,
    input  wire vred_pkg::vreg_t      vec_regb_3,
    input  wire vred_pkg::vreg_t      vec_regb_4,
    input  wire vred_pkg::scalar_t    vec_rega,
    output logic                      ack,
    output vred_pkg::scalar_t         result
);

    wire                 load;
    wire                 step;
    wire                 last;
    vred_pkg::vred_op_e  op_q;
    vred_pkg::vred_sew_e sew_q;

    vred_ctrl u_ctrl (
        .clk      (clk),
        .nrst     (nrst),
        .req      (req),
        .op_instr (op_instr),
        .sew      (sew),
        .lmul     (lmul),
        .ack      (ack),
        .load     (load),
        .step     (step),
        .last     (last),
        .op_q     (op_q),
        .sew_q    (sew_q)
    );

    vred_datapath u_datapath (
        .clk        (clk),
        .nrst       (nrst),
        .load       (load),
        .step       (step),
        .last       (last),
        .op_q       (op_q),
        .sew_q      (sew_q),
        .op_instr   (op_instr),
        .sew        (sew),
        .lmul       (lmul),
        .vec_regb_1 (vec_regb_1),
        .vec_regb_2 (vec_regb_2),
        .vec_regb_3 (vec_regb_3),
        .vec_regb_4 (vec_regb_4),
        .vec_rega   (vec_rega),
        .result     (result)
    );

endmodule

`default_nettype wire

// File: verif/vred_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module vred_clk_gen (
    output logic clk,
    output logic nrst
);

    localparam int HALF_PERIOD_NS = 4;
    localparam int RESET_CYCLES = 10;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial
    begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nrst = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/vred_checker.sv
`timescale 1ns/1ps
`default_nettype none

module vred_checker (
    input wire                       clk,
    input wire                       nrst,
    input wire                       req,
    input wire                       ack,
    input wire vred_pkg::vred_op_e   op_instr,
    input wire vred_pkg::vred_sew_e  sew,
    input wire vred_pkg::vred_lmul_e lmul,
    input wire vred_pkg::scalar_t    result
);

    // assertion failures so far
    int fail_count = 0;

    // ack only answers a pending req
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!nrst)
        $rose(ack) |-> $past(req))
    else
    begin
        fail_count++;
        $error("ack rose without a pending req");
    end

    a_ack_held: assert property (@(posedge clk) disable iff (!nrst)
        (ack && req) |=> ack)
    else
    begin
        fail_count++;
        $error("ack dropped while req was still high");
    end

    a_result_stable: assert property (@(posedge clk) disable iff (!nrst)
        ack |=> $stable(result))
    else
    begin
        fail_count++;
        $error("result changed while ack was high");
    end

    // reserved codes never reach the unit
    a_legal_codes: assert property (@(posedge clk) disable iff (!nrst)
        $rose(req) |-> (op_instr inside {vred_pkg::VRED_VREDSUM, vred_pkg::VRED_VREDMAX})
            && (sew inside {vred_pkg::SEW_8, vred_pkg::SEW_16, vred_pkg::SEW_32})
            && (lmul inside {vred_pkg::LMUL_1, vred_pkg::LMUL_2, vred_pkg::LMUL_4}))
    else
    begin
        fail_count++;
        $error("req raised with an illegal opcode or reserved code");
    end

endmodule

`default_nettype wire

// File: verif/vred_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vred_macros.svh"

module vred_tb;

    localparam int NUM_REQUESTS = 48;
    localparam int CLK_PERIOD_NS = 8;
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * 8 + 20;

    wire                  clk;
    wire                  nrst;
    wire                  ack;
    wire vred_pkg::scalar_t result;
    logic                 req;
    vred_pkg::vred_op_e   op_instr;
    vred_pkg::vred_sew_e  sew;
    vred_pkg::vred_lmul_e lmul;
    vred_pkg::vreg_t      vec_regb_1;
    vred_pkg::vreg_t      vec_regb_2;
    vred_pkg::vreg_t      vec_regb_3;
    vred_pkg::vreg_t      vec_regb_4;
    vred_pkg::scalar_t    vec_rega;
    int                   errors;
    int                   errors_at_start;
    int                   tests_run;
    int                   tests_failed;
    logic [31:0]          rng_state;

    vred_clk_gen u_clk_gen (
        .clk  (clk),
        .nrst (nrst)
    );

    vred_top DUT (
        .clk        (clk),
        .nrst       (nrst),
        .req        (req),
        .op_instr   (op_instr),
        .sew        (sew),
        .lmul       (lmul),
        .vec_regb_1 (vec_regb_1),
        .vec_regb_2 (vec_regb_2),
        .vec_regb_3 (vec_regb_3),
        .vec_regb_4 (vec_regb_4),
        .vec_rega   (vec_rega),
        .ack        (ack),
        .result     (result)
    );

    bind vred_top vred_checker u_checker (
        .clk      (clk),
        .nrst     (nrst),
        .req      (req),
        .ack      (ack),
        .op_instr (op_instr),
        .sew      (sew),
        .lmul     (lmul),
        .result   (result)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic vred_pkg::vreg_t rand_vreg();
        vred_pkg::vreg_t v;
        for (int i = 0; i < `VRED_VLEN / 32; i++)
            v[i*32 +: 32] = next_rand();
        return v;
    endfunction

    function automatic longint to_signed(input logic [31:0] raw, input int ew);
        longint v;
        v = longint'(raw);
        if (raw[ew-1])
            v = v - (longint'(1) << ew);
        return v;
    endfunction

    // fold the active elements, then the scalar, zero-extend at the end
    function automatic vred_pkg::scalar_t model_reduce(
        input vred_pkg::vred_op_e op, input vred_pkg::vred_sew_e s,
        input vred_pkg::vred_lmul_e l, input vred_pkg::vreg_t b1, input vred_pkg::vreg_t b2,
        input vred_pkg::vreg_t b3, input vred_pkg::vreg_t b4, input vred_pkg::scalar_t a);
        vred_pkg::work_t all;
        int              ew;
        int              count;
        logic [31:0]     mask;
        longint          acc;
        longint          val;
        all = {b4, b3, b2, b1};
        ew = 8 << int'(s);
        count = (`VRED_VLEN / ew) << int'(l);
        mask = (ew == 32) ? 32'hffff_ffff : (32'd1 << ew) - 32'd1;
        acc = to_signed(32'(all) & mask, ew);
        for (int i = 1; i <= count; i++)
        begin
            // the pass after the last element brings in the scalar
            val = (i == count) ? to_signed(a & mask, ew)
                               : to_signed(32'(all >> (i * ew)) & mask, ew);
            if (op == vred_pkg::VRED_VREDMAX)
                acc = (val > acc) ? val : acc;
            else
                acc = acc + val;
        end
        return vred_pkg::scalar_t'(acc) & mask;
    endfunction

    function automatic vred_pkg::level_t expected_levels(input vred_pkg::vred_sew_e s,
                                                         input vred_pkg::vred_lmul_e l);
        return vred_pkg::level_t'($clog2((`VRED_VLEN << int'(l)) / (8 << int'(s))));
    endfunction

    task automatic check_result(input string name, input vred_pkg::scalar_t got,
                                input vred_pkg::scalar_t exp);
        if (got !== exp)
        begin
            $display("Error: %s got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input vred_pkg::level_t got,
                                 input vred_pkg::level_t exp);
        if (got !== exp)
        begin
            $display("Error: %s got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != errors_at_start)
        begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_at_start);
        end
        else
            $display("%s: passed", name);
    endtask

    // called 1 ns after an edge with the unit idle
    task automatic run_request(input vred_pkg::vred_op_e op, input vred_pkg::vred_sew_e s,
        input vred_pkg::vred_lmul_e l, input vred_pkg::vreg_t b1, input vred_pkg::vreg_t b2,
        input vred_pkg::vreg_t b3, input vred_pkg::vreg_t b4, input vred_pkg::scalar_t a,
        input int hold_cycles, output vred_pkg::scalar_t res, output vred_pkg::level_t lat);
        int edges;
        if (ack)
        begin
            $display("ack was still high when a new request started");
            errors++;
        end
        op_instr = op;
        sew = s;
        lmul = l;
        vec_regb_1 = b1;
        vec_regb_2 = b2;
        vec_regb_3 = b3;
        vec_regb_4 = b4;
        vec_rega = a;
        req = 1'b1;
        @(posedge clk);
        #1;
        edges = 1;
        // operands are free to change once sampled
        vec_regb_1 = ~b1;
        vec_regb_2 = ~b2;
        vec_regb_3 = ~b3;
        vec_regb_4 = ~b4;
        vec_rega = ~a;
        while (!ack && edges < 10)
        begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (!ack)
        begin
            $display("ack did not rise within %0d edges of the sampling edge", edges);
            errors++;
        end
        lat = (edges > 7) ? vred_pkg::level_t'(7) : vred_pkg::level_t'(edges);
        res = result;
        repeat (hold_cycles)
        begin
            @(posedge clk);
            #1;
            if (!ack)
            begin
                $display("ack dropped while req was held high");
                errors++;
            end
            check_result("result", result, res);
        end
        req = 1'b0;
        @(posedge clk);
        #1;
        if (ack)
        begin
            $display("ack was still high one edge after req fell");
            errors++;
        end
    endtask

    task automatic test_reset_values();
        start_test();
        if (ack !== 1'b0)
        begin
            $display("ack was not low after reset");
            errors++;
        end
        check_result("result", result, '0);
        report_test("reset_values");
    endtask

    task automatic test_sum_modes();
        vred_pkg::vreg_t   b [4];
        vred_pkg::scalar_t res;
        vred_pkg::level_t  lat;
        vred_pkg::vred_sew_e  s;
        vred_pkg::vred_lmul_e l;
        start_test();
        // large lanes so every width wraps
        for (int k = 0; k < 4; k++)
            b[k] = {4{32'hf7e5_d3c1 + 32'h0102_0304 * k}};
        for (int si = 0; si < 3; si++)
        begin
            for (int li = 0; li < 3; li++)
            begin
                s = vred_pkg::vred_sew_e'(si);
                l = vred_pkg::vred_lmul_e'(li);
                run_request(vred_pkg::VRED_VREDSUM, s, l, b[0], b[1], b[2], b[3],
                            32'h89ab_cdef, 0, res, lat);
                check_result("result", res, model_reduce(vred_pkg::VRED_VREDSUM, s, l,
                             b[0], b[1], b[2], b[3], 32'h89ab_cdef));
            end
        end
        report_test("sum_modes");
    endtask

    task automatic test_max_signed();
        vred_pkg::vreg_t   mixed;
        vred_pkg::vreg_t   neg;
        vred_pkg::scalar_t res;
        vred_pkg::level_t  lat;
        vred_pkg::vred_sew_e s;
        start_test();
        mixed = 128'h8081_92a3_b4c5_d6e7_f865_4321_acbd_cedf;
        neg   = 128'h8899_aabb_ccdd_eeff_8090_a0b0_c0d0_e0f0;
        for (int si = 0; si < 3; si++)
        begin
            s = vred_pkg::vred_sew_e'(si);
            run_request(vred_pkg::VRED_VREDMAX, s, vred_pkg::LMUL_2, mixed, neg, '0, '0,
                        32'hffff_fff0, 0, res, lat);
            check_result("result", res, model_reduce(vred_pkg::VRED_VREDMAX, s,
                         vred_pkg::LMUL_2, mixed, neg, '0, '0, 32'hffff_fff0));
        end
        // scalar above every element
        run_request(vred_pkg::VRED_VREDMAX, vred_pkg::SEW_8, vred_pkg::LMUL_2, neg, neg,
                    '0, '0, 32'h0000_7f7f, 0, res, lat);
        check_result("result", res, 32'h0000_007f);
        run_request(vred_pkg::VRED_VREDMAX, vred_pkg::SEW_32, vred_pkg::LMUL_2, neg, neg,
                    '0, '0, 32'h0000_7f7f, 0, res, lat);
        check_result("result", res, 32'h0000_7f7f);
        report_test("max_signed");
    endtask

    task automatic test_inactive_regs();
        vred_pkg::vreg_t    b1;
        vred_pkg::scalar_t  res_big;
        vred_pkg::scalar_t  res_zero;
        vred_pkg::scalar_t  exp_res;
        vred_pkg::level_t   lat;
        vred_pkg::vred_op_e op;
        start_test();
        b1 = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
        for (int oi = 0; oi < 2; oi++)
        begin
            op = vred_pkg::vred_op_e'(oi);
            run_request(op, vred_pkg::SEW_8, vred_pkg::LMUL_1, b1, {16{8'h7f}},
                        {16{8'h7f}}, {16{8'h7f}}, 32'h0000_0011, 0, res_big, lat);
            run_request(op, vred_pkg::SEW_8, vred_pkg::LMUL_1, b1, '0, '0, '0,
                        32'h0000_0011, 0, res_zero, lat);
            exp_res = model_reduce(op, vred_pkg::SEW_8, vred_pkg::LMUL_1, b1, '0, '0, '0,
                                   32'h0000_0011);
            check_result("result", res_big, exp_res);
            check_result("result", res_zero, exp_res);
        end
        report_test("inactive_regs");
    endtask

    task automatic test_latency();
        vred_pkg::scalar_t    res;
        vred_pkg::level_t     lat;
        vred_pkg::vred_sew_e  s;
        vred_pkg::vred_lmul_e l;
        start_test();
        for (int si = 0; si < 3; si++)
        begin
            for (int li = 0; li < 3; li++)
            begin
                s = vred_pkg::vred_sew_e'(si);
                l = vred_pkg::vred_lmul_e'(li);
                run_request(vred_pkg::VRED_VREDMAX, s, l, {8{16'h1357}}, {8{16'h2468}},
                            {8{16'h9abc}}, {8{16'h7def}}, 32'h0000_0000, 0, res, lat);
                check_latency("latency", lat, expected_levels(s, l));
            end
        end
        report_test("latency");
    endtask

    task automatic test_backpressure();
        vred_pkg::scalar_t res;
        vred_pkg::level_t  lat;
        vred_pkg::vreg_t   b [4];
        start_test();
        for (int k = 0; k < 4; k++)
            b[k] = {8{16'(16'hc001 + 16'h1f1f * k)}};
        run_request(vred_pkg::VRED_VREDSUM, vred_pkg::SEW_16, vred_pkg::LMUL_4, b[0], b[1],
                    b[2], b[3], 32'h0000_4321, 5, res, lat);
        check_result("result", res, model_reduce(vred_pkg::VRED_VREDSUM, vred_pkg::SEW_16,
                     vred_pkg::LMUL_4, b[0], b[1], b[2], b[3], 32'h0000_4321));
        report_test("backpressure");
    endtask

    task automatic test_random();
        vred_pkg::vreg_t      b [4];
        vred_pkg::scalar_t    a;
        vred_pkg::scalar_t    res;
        vred_pkg::level_t     lat;
        vred_pkg::vred_op_e   op;
        vred_pkg::vred_sew_e  s;
        vred_pkg::vred_lmul_e l;
        start_test();
        for (int n = 0; n < 20; n++)
        begin
            op = vred_pkg::vred_op_e'(3'(next_rand() % 2));
            s = vred_pkg::vred_sew_e'(2'(next_rand() % 3));
            l = vred_pkg::vred_lmul_e'(2'(next_rand() % 3));
            for (int k = 0; k < 4; k++)
                b[k] = rand_vreg();
            a = next_rand();
            run_request(op, s, l, b[0], b[1], b[2], b[3], a, 0, res, lat);
            check_result("result", res, model_reduce(op, s, l, b[0], b[1], b[2], b[3], a));
        end
        report_test("random");
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        req = 1'b0;
        op_instr = vred_pkg::VRED_VREDSUM;
        sew = vred_pkg::SEW_8;
        lmul = vred_pkg::LMUL_1;
        vec_regb_1 = '0;
        vec_regb_2 = '0;
        vec_regb_3 = '0;
        vec_regb_4 = '0;
        vec_rega = '0;
        errors = 0;
        errors_at_start = 0;
        tests_run = 0;
        tests_failed = 0;
        rng_state = 32'd8;
        wait (nrst === 1'b1);
        @(posedge clk);
        #1;
        test_reset_values();
        test_sum_modes();
        test_max_signed();
        test_inactive_regs();
        test_latency();
        test_backpressure();
        test_random();
        // handshake assertion failures count as errors too
        errors += DUT.u_checker.fail_count;
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+hw
hw/vred_pkg.sv
hw/vred_ctrl.sv
hw/vred_pair_combine.sv
hw/vred_datapath.sv
hw/vred_top.sv
verif/vred_clk_gen.sv
verif/vred_checker.sv
verif/vred_tb.sv
